// File: include/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ######################################################################
// Table sizes
// ######################################################################

// Pattern table index comes from pc[BP_TABLE_INDEX_WIDTH+1:2].
`define BP_TABLE_INDEX_WIDTH 6
`define BP_TABLE_ENTRIES     (1 << `BP_TABLE_INDEX_WIDTH)
`define BP_CTR_INIT          2'b01  // Weakly not taken.

// Return stack pointer width and depth.
`define JR_ENTRY_WIDTH 2
`define JR_ENTRIES     (1 << `JR_ENTRY_WIDTH)

// ######################################################################
// MIPS encodings
// ######################################################################

`define OP_RT   6'b000000  // SPECIAL group.
`define OP_BGEZ 6'b000001  // REGIMM group.
`define OP_J    6'b000010
`define OP_JAL  6'b000011
`define OP_BEQ  6'b000100
`define OP_BNE  6'b000101
`define OP_BLEZ 6'b000110
`define OP_BGTZ 6'b000111

`define F_JR    6'b001000
`define F_JALR  6'b001001

// Linking variants in the rt field of REGIMM.
`define B_BLTZAL 5'b10000
`define B_BGEZAL 5'b10001

`define REG_RA 5'd31

`endif

// File: src/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // ##################################################################
    // Basic fields
    // ##################################################################

    typedef logic [31:0] word_t;

    typedef logic [5:0] op_t;

    typedef logic [5:0] func_t;

    // ##################################################################
    // Prediction result
    // ##################################################################

    // Counter lookup only fills taken. The predecoder fills both.
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

endpackage

`default_nettype wire

// File: src/fetch_capture.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_capture (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic          fetch_valid,
    input  wire bp_pkg::word_t fetch_pc,
    input  wire bp_pkg::word_t fetch_instr,
    input  wire logic          flush,
    output logic               cap_valid,
    output bp_pkg::word_t      cap_pc,
    output bp_pkg::word_t      cap_instr
);

    // Slot valid bit.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cap_valid <= 1'b0;
        end
        else
        begin
            cap_valid <= fetch_valid & ~flush;  // A flush drops the incoming fetch.
        end
    end

    // Payload holds its value on idle cycles.
    always_ff @(posedge clk)
    begin
        if (fetch_valid)
        begin
            cap_pc    <= fetch_pc;
            cap_instr <= fetch_instr;
        end
    end

endmodule

`default_nettype wire

// File: src/pattern_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module pattern_table (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire bp_pkg::word_t  lookup_pc,
    input  wire logic           resolve_valid,
    input  wire bp_pkg::word_t  resolve_pc,
    input  wire logic           resolve_taken,
    output bp_pkg::bpb_result_t lookup
);

    logic [1:0] ctr [`BP_TABLE_ENTRIES];

    logic [`BP_TABLE_INDEX_WIDTH-1:0] lookup_idx;
    logic [`BP_TABLE_INDEX_WIDTH-1:0] train_idx;

    assign lookup_idx = lookup_pc[`BP_TABLE_INDEX_WIDTH+1:2];
    assign train_idx  = resolve_pc[`BP_TABLE_INDEX_WIDTH+1:2];

    // ##################################################################
    // Lookup
    // ##################################################################

    assign lookup.taken  = ctr[lookup_idx][1];  // Upper half of the counter range.
    assign lookup.destpc = '0;

    // ##################################################################
    // Training
    // ##################################################################

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `BP_TABLE_ENTRIES; i++)
            begin
                ctr[i] <= `BP_CTR_INIT;
            end
        end
        else if (resolve_valid)
        begin
            if (resolve_taken && ctr[train_idx] != 2'b11)
            begin
                ctr[train_idx] <= ctr[train_idx] + 2'b01;
            end
            else if (!resolve_taken && ctr[train_idx] != 2'b00)
            begin
                ctr[train_idx] <= ctr[train_idx] - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/return_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module return_stack (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       cap_valid,
    input  wire bp_pkg::word_t              cap_pc,
    input  wire logic                       jr_push,
    input  wire logic                       jr_pop,
    input  wire logic [`JR_ENTRY_WIDTH-1:0] jr_topF_out,
    output logic [`JR_ENTRY_WIDTH-1:0]      jr_topF_in,
    output bp_pkg::word_t                   jr_destpc
);

    bp_pkg::word_t ras [`JR_ENTRIES];

    logic [`JR_ENTRY_WIDTH-1:0] top;

    assign jr_topF_in = top;
    assign jr_destpc  = ras[top];

    // The pointer wraps, so a deep call chain overwrites the oldest entry.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            top <= '0;
            for (int i = 0; i < `JR_ENTRIES; i++)
            begin
                ras[i] <= '0;
            end
        end
        else if (cap_valid)
        begin
            if (jr_push | jr_pop)
            begin
                top <= jr_topF_out;
            end
            if (jr_push)
            begin
                ras[jr_topF_out] <= cap_pc + 32'd8;  // Skip the delay slot.
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bpb_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module bpb_decode (
    input  wire bp_pkg::word_t              pc,
    input  wire bp_pkg::word_t              instr,
    input  wire bp_pkg::bpb_result_t        in,
    input  wire bp_pkg::word_t              jr_destpc,
    input  wire logic [`JR_ENTRY_WIDTH-1:0] jr_topF_in,
    output bp_pkg::bpb_result_t             out,
    output logic                            jr_push,
    output logic                            jr_pop,
    output logic [`JR_ENTRY_WIDTH-1:0]      jr_topF_out
);

    localparam int unsigned PTR_W = `JR_ENTRY_WIDTH;

    bp_pkg::op_t   op;
    bp_pkg::func_t func;
    logic [4:0]    rs;
    logic [4:0]    rt;

    assign op   = instr[31:26];
    assign func = instr[5:0];
    assign rs   = instr[25:21];
    assign rt   = instr[20:16];

    // ##################################################################
    // Classification
    // ##################################################################

    logic is_jump;
    logic is_branch;
    logic is_jr;

    always_comb
    begin
        is_jump   = 1'b0;
        is_branch = 1'b0;
        is_jr     = 1'b0;
        jr_push   = 1'b0;
        jr_pop    = 1'b0;
        case (op)
            `OP_J:
            begin
                is_jump = 1'b1;
            end
            `OP_JAL:
            begin
                is_jump = 1'b1;
                jr_push = 1'b1;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ:
            begin
                is_branch = 1'b1;
            end
            `OP_BGEZ:
            begin
                is_branch = 1'b1;
                jr_push   = (rt == `B_BGEZAL) || (rt == `B_BLTZAL);  // Linking forms.
            end
            `OP_RT:
            begin
                is_jr   = (func == `F_JR) || (func == `F_JALR);
                jr_pop  = is_jr && (rs == `REG_RA);  // Only returns through ra.
                jr_push = (func == `F_JALR);
            end
            default:
            begin
                is_jump = 1'b0;
            end
        endcase
    end

    // ##################################################################
    // Targets
    // ##################################################################

    bp_pkg::word_t pcplus4;
    bp_pkg::word_t ext_imm;
    bp_pkg::word_t pcjump;
    bp_pkg::word_t pcbranch;

    assign pcplus4  = pc + 32'd4;
    assign ext_imm  = {{16{instr[15]}}, instr[15:0]};
    assign pcjump   = {pcplus4[31:28], instr[25:0], 2'b00};
    assign pcbranch = pcplus4 + {ext_imm[29:0], 2'b00};

    assign out.taken = is_jump | is_jr | (is_branch & in.taken);

    always_comb
    begin
        if (is_jump)
            out.destpc = pcjump;
        else if (is_branch)
            out.destpc = pcbranch;
        else if (is_jr)
            out.destpc = jr_destpc;
        else
            out.destpc = '0;
    end

    // Next stack pointer. Push with pop keeps it in place.
    always_comb
    begin
        case ({jr_push, jr_pop})
            2'b10:   jr_topF_out = jr_topF_in + PTR_W'(1);
            2'b01:   jr_topF_out = jr_topF_in - PTR_W'(1);
            default: jr_topF_out = jr_topF_in;
        endcase
    end

endmodule

`default_nettype wire

// File: src/prediction_out.sv
`timescale 1ns/1ps
`default_nettype none

module prediction_out (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                cap_valid,
    input  wire bp_pkg::word_t       cap_pc,
    input  wire bp_pkg::bpb_result_t decoded,
    input  wire logic                flush,
    output logic                     pred_valid,
    output bp_pkg::word_t            pred_pc,
    output logic                     pred_taken,
    output bp_pkg::word_t            pred_target
);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pred_valid <= 1'b0;
        end
        else
        begin
            pred_valid <= cap_valid & ~flush;  // Kill the slot on a mispredict.
        end
    end

    always_ff @(posedge clk)
    begin
        if (cap_valid)
        begin
            pred_pc     <= cap_pc;
            pred_taken  <= decoded.taken;
            pred_target <= decoded.destpc;
        end
    end

endmodule

`default_nettype wire

// File: src/branch_predictor_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module branch_predictor_top (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic          fetch_valid,
    input  wire bp_pkg::word_t fetch_pc,
    input  wire bp_pkg::word_t fetch_instr,
    input  wire logic          resolve_valid,
    input  wire bp_pkg::word_t resolve_pc,
    input  wire logic          resolve_taken,
    input  wire logic          resolve_mispredict,
    output logic               pred_valid,
    output bp_pkg::word_t      pred_pc,
    output logic               pred_taken,
    output bp_pkg::word_t      pred_target
);

    // ##################################################################
    // Internal wires
    // ##################################################################

    wire flush = resolve_valid & resolve_mispredict;

    logic                       cap_valid;
    bp_pkg::word_t              cap_pc;
    bp_pkg::word_t              cap_instr;
    bp_pkg::bpb_result_t        pt_lookup;
    bp_pkg::bpb_result_t        decoded;
    bp_pkg::word_t              jr_destpc;
    logic                       jr_push;
    logic                       jr_pop;
    logic [`JR_ENTRY_WIDTH-1:0] jr_topF_in;
    logic [`JR_ENTRY_WIDTH-1:0] jr_topF_out;

    // ##################################################################
    // Stages
    // ##################################################################

    fetch_capture u_fetch_capture (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .flush       (flush),
        .cap_valid   (cap_valid),
        .cap_pc      (cap_pc),
        .cap_instr   (cap_instr)
    );

    pattern_table u_pattern_table (
        .clk           (clk),
        .arst_n        (arst_n),
        .lookup_pc     (cap_pc),
        .resolve_valid (resolve_valid),
        .resolve_pc    (resolve_pc),
        .resolve_taken (resolve_taken),
        .lookup        (pt_lookup)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .arst_n      (arst_n),
        .cap_valid   (cap_valid),
        .cap_pc      (cap_pc),
        .jr_push     (jr_push),
        .jr_pop      (jr_pop),
        .jr_topF_out (jr_topF_out),
        .jr_topF_in  (jr_topF_in),
        .jr_destpc   (jr_destpc)
    );

    bpb_decode u_bpb_decode (
        .pc          (cap_pc),
        .instr       (cap_instr),
        .in          (pt_lookup),
        .jr_destpc   (jr_destpc),
        .jr_topF_in  (jr_topF_in),
        .out         (decoded),
        .jr_push     (jr_push),
        .jr_pop      (jr_pop),
        .jr_topF_out (jr_topF_out)
    );

    prediction_out u_prediction_out (
        .clk         (clk),
        .arst_n      (arst_n),
        .cap_valid   (cap_valid),
        .cap_pc      (cap_pc),
        .decoded     (decoded),
        .flush       (flush),
        .pred_valid  (pred_valid),
        .pred_pc     (pred_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target)
    );

endmodule

`default_nettype wire

// File: sim/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module tb_branch_predictor;

    localparam int WAIT_LIMIT = 20;
    localparam int RAS_W      = `JR_ENTRY_WIDTH;

    logic        clk;
    logic        arst_n;
    logic        fetch_valid;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_instr;
    logic        resolve_valid;
    logic [31:0] resolve_pc;
    logic        resolve_taken;
    logic        resolve_mispredict;
    logic        pred_valid;
    logic [31:0] pred_pc;
    logic        pred_taken;
    logic [31:0] pred_target;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    logic [15:0] lfsr;

    // Reference model state.
    logic [1:0]                 ctr_model [`BP_TABLE_ENTRIES];
    logic [31:0]                ras_model [`JR_ENTRIES];
    logic [`JR_ENTRY_WIDTH-1:0] top_model;
    logic                       exp_taken;
    logic [31:0]                exp_target;

    branch_predictor_top dut0 (
        .clk                (clk),
        .arst_n             (arst_n),
        .fetch_valid        (fetch_valid),
        .fetch_pc           (fetch_pc),
        .fetch_instr        (fetch_instr),
        .resolve_valid      (resolve_valid),
        .resolve_pc         (resolve_pc),
        .resolve_taken      (resolve_taken),
        .resolve_mispredict (resolve_mispredict),
        .pred_valid         (pred_valid),
        .pred_pc            (pred_pc),
        .pred_taken         (pred_taken),
        .pred_target        (pred_target)
    );

    always #5 clk = ~clk;

    // ##################################################################
    // Stimulus helpers
    // ##################################################################

    // Fibonacci LFSR with taps 16 14 13 11.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic train_model(input logic [31:0] pc, input logic taken);
        logic [`BP_TABLE_INDEX_WIDTH-1:0] idx;
        idx = pc[`BP_TABLE_INDEX_WIDTH+1:2];
        if (taken && ctr_model[idx] != 2'b11)
        begin
            ctr_model[idx] = ctr_model[idx] + 2'b01;
        end
        else if (!taken && ctr_model[idx] != 2'b00)
        begin
            ctr_model[idx] = ctr_model[idx] - 2'b01;
        end
    endtask

    // Expected prediction and stack update for one fetch.
    task automatic model_fetch(input logic [31:0] pc, input logic [31:0] instr);
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [5:0]  funct;
        logic [31:0] pc4;
        logic [31:0] offset;
        logic        push;
        logic        pop;
        op         = instr[31:26];
        rs         = instr[25:21];
        rt         = instr[20:16];
        funct      = instr[5:0];
        pc4        = pc + 32'd4;
        offset     = {{14{instr[15]}}, instr[15:0], 2'b00};
        push       = 1'b0;
        pop        = 1'b0;
        exp_taken  = 1'b0;
        exp_target = '0;
        if (op == `OP_J || op == `OP_JAL)
        begin
            exp_taken  = 1'b1;
            exp_target = {pc4[31:28], instr[25:0], 2'b00};
            push       = (op == `OP_JAL);
        end
        else if (op == `OP_BEQ || op == `OP_BNE || op == `OP_BLEZ || op == `OP_BGTZ
                 || op == `OP_BGEZ)
        begin
            exp_taken  = ctr_model[pc[`BP_TABLE_INDEX_WIDTH+1:2]][1];
            exp_target = pc4 + offset;
            push       = (op == `OP_BGEZ) && (rt == `B_BGEZAL || rt == `B_BLTZAL);
        end
        else if (op == `OP_RT && (funct == `F_JR || funct == `F_JALR))
        begin
            exp_taken  = 1'b1;
            exp_target = ras_model[top_model];  // Read before the update.
            pop        = (rs == `REG_RA);
            push       = (funct == `F_JALR);
        end
        if (push && !pop)
            top_model = top_model + RAS_W'(1);
        else if (pop && !push)
            top_model = top_model - RAS_W'(1);
        if (push)
            ras_model[top_model] = pc + 32'd8;
    endtask

    task automatic drive_fetch(input logic [31:0] pc, input logic [31:0] instr);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_instr = instr;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic drive_resolve(input logic [31:0] pc, input logic taken);
        @(negedge clk);
        resolve_valid = 1'b1;
        resolve_pc    = pc;
        resolve_taken = taken;
        @(negedge clk);
        resolve_valid = 1'b0;
        train_model(pc, taken);
    endtask

    task automatic wait_prediction(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT)
        begin
            if (pred_valid)
            begin
                seen = 1'b1;
            end
            else
            begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
            test_errors++;
        end
    endtask

    task automatic predict_and_check(input logic [31:0] pc, input logic [31:0] instr);
        logic seen;
        model_fetch(pc, instr);
        drive_fetch(pc, instr);
        wait_prediction(seen);
        if (!seen)
        begin
            $display("timeout at %0t: no prediction came out for pc %h", $time, pc);
            test_errors++;
        end
        else
        begin
            check_value("pred_pc", pred_pc, pc);
            check_value("pred_taken", {31'b0, pred_taken}, {31'b0, exp_taken});
            check_value("pred_target", pred_target, exp_target);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ##################################################################
    // Tests
    // ##################################################################

    task automatic test_reset_alu();
        check_value("pred_valid", {31'b0, pred_valid}, 32'd0);
        predict_and_check(32'h0000_0100, 32'h0085_1020);  // add $2, $4, $5
    endtask

    task automatic test_jumps();
        logic [31:0] rnd;
        rnd = rand_bits(26);
        predict_and_check(32'h0040_0010, {`OP_J, rnd[25:0]});
        rnd = rand_bits(26);
        predict_and_check(32'h1000_2000, {`OP_JAL, rnd[25:0]});
        rnd = rand_bits(26);
        predict_and_check(32'h2FFF_FFFC, {`OP_J, rnd[25:0]});  // pc+4 crosses a segment.
    endtask

    task automatic test_branches();
        logic [31:0] rnd;
        logic [31:0] beq;
        logic [31:0] bne;
        rnd = rand_bits(16);
        beq = {`OP_BEQ, 5'd1, 5'd2, rnd[15:0]};
        bne = {`OP_BNE, 5'd3, 5'd4, ~rnd[15:0]};
        predict_and_check(32'h0000_0210, beq);
        drive_resolve(32'h0000_0210, 1'b1);
        drive_resolve(32'h0000_0210, 1'b1);
        predict_and_check(32'h0000_0210, beq);
        predict_and_check(32'h0000_0220, bne);  // The BEQ counter is strongly taken here.
        drive_resolve(32'h0000_0210, 1'b0);
        drive_resolve(32'h0000_0210, 1'b0);
        drive_resolve(32'h0000_0210, 1'b0);
        predict_and_check(32'h0000_0210, beq);
    endtask

    task automatic test_calls();
        logic [31:0] rnd;
        logic [31:0] ret_instr;
        ret_instr = {`OP_RT, `REG_RA, 15'd0, `F_JR};
        rnd = rand_bits(26);
        predict_and_check(32'h0000_3000, {`OP_JAL, rnd[25:0]});
        predict_and_check(32'h0000_4000, ret_instr);
        check_value("pred_target", pred_target, 32'h0000_3008);
        for (int i = 0; i < 5; i++)
        begin
            rnd = rand_bits(26);
            predict_and_check(32'h0000_5000 + i * 256, {`OP_JAL, rnd[25:0]});
        end
        for (int i = 0; i < 5; i++)
        begin
            predict_and_check(32'h0000_6000 + i * 16, ret_instr);
        end
        check_value("pred_target", pred_target, 32'h0000_5408);  // Fifth call wrapped.
    endtask

    task automatic test_flush();
        logic [31:0] rnd;
        logic        leaked;
        rnd = rand_bits(26);
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch_pc    = 32'h0000_7000;
        fetch_instr = {`OP_J, rnd[25:0]};
        @(negedge clk);
        fetch_pc           = 32'h0000_7004;
        fetch_instr        = 32'h0085_1020;
        resolve_valid      = 1'b1;
        resolve_pc         = 32'h0000_0300;
        resolve_taken      = 1'b1;
        resolve_mispredict = 1'b1;
        train_model(32'h0000_0300, 1'b1);  // A mispredict still trains.
        @(negedge clk);
        fetch_valid        = 1'b0;
        resolve_valid      = 1'b0;
        resolve_mispredict = 1'b0;
        leaked = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (pred_valid)
                leaked = 1'b1;
            @(negedge clk);
        end
        if (leaked)
        begin
            $display("error at %0t: a flushed fetch still produced a prediction", $time);
            test_errors++;
        end
        predict_and_check(32'h0000_7008, {`OP_BEQ, 5'd0, 5'd0, 16'h0010});
    endtask

    // ##################################################################
    // Main sequence
    // ##################################################################

    initial
    begin
        clk                = 1'b0;
        arst_n             = 1'b0;
        fetch_valid        = 1'b0;
        fetch_pc           = '0;
        fetch_instr        = '0;
        resolve_valid      = 1'b0;
        resolve_pc         = '0;
        resolve_taken      = 1'b0;
        resolve_mispredict = 1'b0;
        errors             = 0;
        test_errors        = 0;
        tests_run          = 0;
        tests_failed       = 0;
        lfsr               = 16'd31863;
        top_model          = '0;
        for (int i = 0; i < `BP_TABLE_ENTRIES; i++)
        begin
            ctr_model[i] = `BP_CTR_INIT;
        end
        for (int i = 0; i < `JR_ENTRIES; i++)
        begin
            ras_model[i] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_alu();
        finish_test("reset_alu");
        test_jumps();
        finish_test("jumps");
        test_branches();
        finish_test("branches");
        test_calls();
        finish_test("calls");
        test_flush();
        finish_test("flush");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
src/bp_pkg.sv
src/fetch_capture.sv
src/pattern_table.sv
src/return_stack.sv
src/bpb_decode.sv
src/prediction_out.sv
src/branch_predictor_top.sv
sim/tb_branch_predictor.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_branch_predictor
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
